// ==== ft_alu_consts.svh ====
`ifndef FT_ALU_CONSTS_SVH
`define FT_ALU_CONSTS_SVH

////////////////////////////////////////////////////////////
// datapath sizing
////////////////////////////////////////////////////////////

// operand and result width of every replica
`define FT_XLEN 32

// opcode field width, wide enough for the ten alu operations
`define FT_OP_W 4

////////////////////////////////////////////////////////////
// redundancy sizing
////////////////////////////////////////////////////////////

// four physical replicas, one of them always on standby
`define FT_NUM_UNITS 4
// three replicas feed the majority voters
`define FT_NUM_SLOTS 3
// bits needed to name one physical unit
`define FT_UNIT_IDX_W 2

// per-unit saturating error counter
`define FT_ERR_CNT_W 4
// count at which a unit is declared permanently faulty
`define FT_ERR_THRESHOLD 8

`endif

// ==== ft_alu_pkg.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

package ft_alu_pkg;

	////////////////////////////////////////////////////////////
	// operation encoding
	////////////////////////////////////////////////////////////

	// arithmetic, logic, shift and compare operations
	typedef enum logic [`FT_OP_W-1:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLL  = 4'h5,
		ALU_SRL  = 4'h6,
		// compares below return their flag on cmp and in result bit 0
		ALU_SLT  = 4'h7,
		ALU_SLTU = 4'h8,
		ALU_EQ   = 4'h9
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// replica requests
	////////////////////////////////////////////////////////////

	// one operation for one replica, 68 bits
	typedef struct packed {
		alu_op_e               op;
		logic [`FT_XLEN-1:0]   operand_a;
		logic [`FT_XLEN-1:0]   operand_b;
	} alu_req_t;

	// one request per physical unit, index is the unit number
	typedef alu_req_t [`FT_NUM_UNITS-1:0] alu_req_vec_t;

endpackage

`default_nettype wire

// ==== ft_status_pkg.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

package ft_status_pkg;

	// physical unit number
	typedef logic [`FT_UNIT_IDX_W-1:0] unit_idx_t;

	// one bit per physical unit
	typedef logic [`FT_NUM_UNITS-1:0] unit_mask_t;

	// one bit per voter slot
	typedef logic [`FT_NUM_SLOTS-1:0] slot_mask_t;

	////////////////////////////////////////////////////////////
	// voted output and fault status
	////////////////////////////////////////////////////////////

	// registered output of the vote stage, 40 bits
	typedef struct packed {
		logic                  valid;
		logic [`FT_XLEN-1:0]   result;
		logic                  cmp;
		logic                  err_detected;
		logic                  err_corrected;
		unit_mask_t            unit_err;
	} vote_out_t;

	// sticky fault flags and the one-shot pulse that goes with them
	typedef struct packed {
		unit_mask_t perm_faulty;
		unit_mask_t perf_pulse;
	} fault_status_t;

endpackage

`default_nettype wire

// ==== ft_issue_reg.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module ft_issue_reg
	import ft_alu_pkg::*;
	import ft_status_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst_i,

	input  wire logic   valid_i,
	input  alu_req_vec_t req_i,
	input  unit_idx_t    spare_sel_i,

	output logic         issue_valid_o,
	output alu_req_vec_t issue_req_o,
	output unit_idx_t    issue_spare_o
);

	logic         valid_q;
	alu_req_vec_t req_q;
	unit_idx_t    spare_q;

	// strobe register, the only control state here
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid_i;
		end
	end

	// requests and standby index move together
	// so a new spare takes effect with its own operation
	always_ff @(posedge clk) begin
		if (valid_i) begin
			req_q   <= req_i;
			spare_q <= spare_sel_i;
		end
	end

	assign issue_valid_o = valid_q;
	assign issue_req_o   = req_q;
	assign issue_spare_o = spare_q;

endmodule

`default_nettype wire

// ==== ft_alu_core.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module ft_alu_core
	import ft_alu_pkg::*;
(
	input  alu_req_t                req_i,

	output logic [`FT_XLEN-1:0]     result_o,
	output logic                    cmp_o
);

	logic [`FT_XLEN-1:0] op_a;
	logic [`FT_XLEN-1:0] op_b;
	// shift amount, low bits of operand b only
	logic [4:0]          shamt;
	logic                cmp_bit;

	assign op_a  = req_i.operand_a;
	assign op_b  = req_i.operand_b;
	assign shamt = op_b[4:0];

	////////////////////////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////////////////////////

	always_comb begin
		result_o = '0;
		cmp_bit  = 1'b0;
		case (req_i.op)
			ALU_ADD: result_o = op_a + op_b;
			ALU_SUB: result_o = op_a - op_b;
			ALU_AND: result_o = op_a & op_b;
			ALU_OR:  result_o = op_a | op_b;
			ALU_XOR: result_o = op_a ^ op_b;
			ALU_SLL: result_o = op_a << shamt;
			ALU_SRL: result_o = op_a >> shamt;
			// compares also show up in bit 0 of the result
			ALU_SLT: begin
				cmp_bit     = $signed(op_a) < $signed(op_b);
				result_o[0] = cmp_bit;
			end
			ALU_SLTU: begin
				cmp_bit     = op_a < op_b;
				result_o[0] = cmp_bit;
			end
			ALU_EQ: begin
				cmp_bit     = op_a == op_b;
				result_o[0] = cmp_bit;
			end
			// unused encodings give zero
			default: begin
				result_o = '0;
			end
		endcase
	end

	// flag stays low for non-compare ops
	assign cmp_o = cmp_bit;

endmodule

`default_nettype wire

// ==== ft_majority_voter.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module ft_majority_voter
	import ft_status_pkg::*;
#(
	// voted payload, a data word or a single flag
	parameter type payload_t = logic
)
(
	// one input per voter slot
	input  payload_t [`FT_NUM_SLOTS-1:0] in_i,

	output payload_t                     voted_o,
	output slot_mask_t                   slot_err_o
);

	payload_t voted;

	////////////////////////////////////////////////////////////
	// two-of-three majority, each bit on its own
	////////////////////////////////////////////////////////////

	// a bit is set when at least two slots agree on a one
	assign voted = (in_i[0] & in_i[1]) |
	               (in_i[0] & in_i[2]) |
	               (in_i[1] & in_i[2]);

	assign voted_o = voted;

	// slot disagreement against the voted value
	// with bitwise voting two slots may be flagged at once
	always_comb begin
		slot_err_o = '0;
		for (int k = 0; k < `FT_NUM_SLOTS; k++) begin
			slot_err_o[k] = in_i[k] != voted;
		end
	end

endmodule

`default_nettype wire

// ==== ft_vote_stage.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module ft_vote_stage
	import ft_alu_pkg::*;
	import ft_status_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst_i,

	input  wire logic    issue_valid_i,
	input  alu_req_vec_t issue_req_i,
	input  unit_idx_t    issue_spare_i,

	output vote_out_t    vote_o
);

	// replica outputs, indexed by physical unit
	logic [`FT_NUM_UNITS-1:0][`FT_XLEN-1:0] core_result;
	logic [`FT_NUM_UNITS-1:0]               core_cmp;

	// physical unit sitting in each voter slot
	unit_idx_t [`FT_NUM_SLOTS-1:0]          slot_unit;
	logic [`FT_NUM_SLOTS-1:0][`FT_XLEN-1:0] slot_result;
	logic [`FT_NUM_SLOTS-1:0]               slot_cmp;

	logic [`FT_XLEN-1:0] voted_result;
	logic                voted_cmp;
	slot_mask_t          res_slot_err;
	slot_mask_t          cmp_slot_err;
	slot_mask_t          slot_any_err;

	unit_mask_t          unit_err_d;
	logic                err_det_d;
	logic                err_cor_d;

	// output register, control part
	logic                valid_q;
	logic                err_det_q;
	logic                err_cor_q;
	unit_mask_t          unit_err_q;
	// output register, payload part
	logic [`FT_XLEN-1:0] result_q;
	logic                cmp_q;

	////////////////////////////////////////////////////////////
	// four replicas
	////////////////////////////////////////////////////////////

	for (genvar u = 0; u < `FT_NUM_UNITS; u++) begin : g_core
		ft_alu_core u_ft_alu_core (
			.req_i    (issue_req_i[u]),
			.result_o (core_result[u]),
			.cmp_o    (core_cmp[u])
		);
	end

	////////////////////////////////////////////////////////////
	// spare selection
	////////////////////////////////////////////////////////////

	// slot k gets the k-th lowest unit that is not on standby
	always_comb begin
		for (int k = 0; k < `FT_NUM_SLOTS; k++) begin
			if (unit_idx_t'(k) < issue_spare_i) begin
				slot_unit[k] = unit_idx_t'(k);
			end else begin
				slot_unit[k] = unit_idx_t'(k + 1);
			end
			slot_result[k] = core_result[slot_unit[k]];
			slot_cmp[k]    = core_cmp[slot_unit[k]];
		end
	end

	ft_majority_voter #(
		.payload_t (logic [`FT_XLEN-1:0])
	) u_voter_result (
		.in_i       (slot_result),
		.voted_o    (voted_result),
		.slot_err_o (res_slot_err)
	);

	ft_majority_voter #(
		.payload_t (logic)
	) u_voter_cmp (
		.in_i       (slot_cmp),
		.voted_o    (voted_cmp),
		.slot_err_o (cmp_slot_err)
	);

	////////////////////////////////////////////////////////////
	// error steering and flags
	////////////////////////////////////////////////////////////

	assign slot_any_err = res_slot_err | cmp_slot_err;

	// map slot flags back to units, standby bit is never written
	always_comb begin
		unit_err_d = '0;
		if (issue_valid_i) begin
			for (int k = 0; k < `FT_NUM_SLOTS; k++) begin
				unit_err_d[slot_unit[k]] = slot_any_err[k];
			end
		end
	end

	assign err_det_d = issue_valid_i & (|slot_any_err);
	// a single bad slot is outvoted by the other two
	assign err_cor_d = issue_valid_i & ($countones(slot_any_err) == 1);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q    <= 1'b0;
			err_det_q  <= 1'b0;
			err_cor_q  <= 1'b0;
			unit_err_q <= '0;
		end else begin
			valid_q    <= issue_valid_i;
			err_det_q  <= err_det_d;
			err_cor_q  <= err_cor_d;
			unit_err_q <= unit_err_d;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid_i) begin
			result_q <= voted_result;
			cmp_q    <= voted_cmp;
		end
	end

	assign vote_o = '{
		valid:         valid_q,
		result:        result_q,
		cmp:           cmp_q,
		err_detected:  err_det_q,
		err_corrected: err_cor_q,
		unit_err:      unit_err_q
	};

endmodule

`default_nettype wire

// ==== ft_fault_monitor.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module ft_fault_monitor
	import ft_status_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst_i,

	input  vote_out_t    vote_i,

	output fault_status_t status_o
);

	localparam logic [`FT_ERR_CNT_W-1:0] ERR_THR = `FT_ERR_CNT_W'(`FT_ERR_THRESHOLD);
	localparam logic [`FT_ERR_CNT_W-1:0] CNT_MAX = '1;

	// one saturating counter per physical unit
	logic [`FT_NUM_UNITS-1:0][`FT_ERR_CNT_W-1:0] err_cnt_q;
	logic [`FT_NUM_UNITS-1:0][`FT_ERR_CNT_W-1:0] err_cnt_d;

	unit_mask_t perm_q;
	unit_mask_t perm_d;
	unit_mask_t pulse_q;

	////////////////////////////////////////////////////////////
	// counting and threshold
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int u = 0; u < `FT_NUM_UNITS; u++) begin
			err_cnt_d[u] = err_cnt_q[u];
			// hold at max instead of wrapping
			if (vote_i.valid && vote_i.unit_err[u] && err_cnt_q[u] != CNT_MAX) begin
				err_cnt_d[u] = err_cnt_q[u] + 1'b1;
			end
			// flag is sticky once the threshold is seen
			perm_d[u] = perm_q[u] | (err_cnt_d[u] >= ERR_THR);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			err_cnt_q <= '0;
			perm_q    <= '0;
			pulse_q   <= '0;
		end else begin
			err_cnt_q <= err_cnt_d;
			perm_q    <= perm_d;
			// rising edge only, so a single cycle per unit
			pulse_q   <= perm_d & ~perm_q;
		end
	end

	assign status_o = '{
		perm_faulty: perm_q,
		perf_pulse:  pulse_q
	};

endmodule

`default_nettype wire

// ==== ft_alu_top.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module ft_alu_top
	import ft_alu_pkg::*;
	import ft_status_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          rst_i,

	// operation strobe and per-replica requests
	input  wire logic          valid_i,
	input  alu_req_vec_t       req_i,
	input  unit_idx_t          spare_sel_i,

	// voted result, two cycles after the strobe is sampled
	output logic               valid_o,
	output logic [`FT_XLEN-1:0] result_o,
	output logic               cmp_o,
	output logic               err_detected_o,
	output logic               err_corrected_o,

	// fault status, one cycle behind the voted result
	output unit_mask_t         perm_faulty_o,
	output unit_mask_t         perf_pulse_o
);

	logic          issue_valid;
	alu_req_vec_t  issue_req;
	unit_idx_t     issue_spare;
	vote_out_t     vote;
	fault_status_t status;

	////////////////////////////////////////////////////////////
	// issue, vote, monitor
	////////////////////////////////////////////////////////////

	ft_issue_reg u_ft_issue_reg (
		.clk           (clk),
		.rst_i         (rst_i),
		.valid_i       (valid_i),
		.req_i         (req_i),
		.spare_sel_i   (spare_sel_i),
		.issue_valid_o (issue_valid),
		.issue_req_o   (issue_req),
		.issue_spare_o (issue_spare)
	);

	ft_vote_stage u_ft_vote_stage (
		.clk           (clk),
		.rst_i         (rst_i),
		.issue_valid_i (issue_valid),
		.issue_req_i   (issue_req),
		.issue_spare_i (issue_spare),
		.vote_o        (vote)
	);

	ft_fault_monitor u_ft_fault_monitor (
		.clk      (clk),
		.rst_i    (rst_i),
		.vote_i   (vote),
		.status_o (status)
	);

	assign valid_o         = vote.valid;
	assign result_o        = vote.result;
	assign cmp_o           = vote.cmp;
	assign err_detected_o  = vote.err_detected;
	assign err_corrected_o = vote.err_corrected;
	assign perm_faulty_o   = status.perm_faulty;
	assign perf_pulse_o    = status.perf_pulse;

endmodule

`default_nettype wire

// ==== tb_ft_alu_top.sv ====
`default_nettype none

`include "ft_alu_consts.svh"

module tb_ft_alu_top
	import ft_alu_pkg::*;
	import ft_status_pkg::*;
();

	localparam int CNT_SAT = (1 << `FT_ERR_CNT_W) - 1;

	logic          clk;
	logic          rst_i;
	logic          valid_i;
	alu_req_vec_t  req_i;
	unit_idx_t     spare_sel_i;
	logic          valid_o;
	logic [`FT_XLEN-1:0] result_o;
	logic          cmp_o;
	logic          err_detected_o;
	logic          err_corrected_o;
	unit_mask_t    perm_faulty_o;
	unit_mask_t    perf_pulse_o;

	// expected votes in issue order
	vote_out_t     exp_q[$];
	string         phase_name;
	// fault monitor model
	int            cnt_m [`FT_NUM_UNITS];
	unit_mask_t    perm_m;
	unit_mask_t    pulse_m;
	int            pulse_seen [`FT_NUM_UNITS];

	ft_alu_top u_ft_alu_top (
		.clk             (clk),
		.rst_i           (rst_i),
		.valid_i         (valid_i),
		.req_i           (req_i),
		.spare_sel_i     (spare_sel_i),
		.valid_o         (valid_o),
		.result_o        (result_o),
		.cmp_o           (cmp_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o),
		.perm_faulty_o   (perm_faulty_o),
		.perf_pulse_o    (perf_pulse_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reporting and compare tasks
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_vote(input string name, input vote_out_t exp, input vote_out_t act);
		vote_out_t e;
		vote_out_t a;
		e = exp;
		a = act;
		// unit_err reaches no top port and drops out of the compare
		e.unit_err = '0;
		a.unit_err = '0;
		if (e !== a) begin
			$display("Fail %s expected %h actual %h", name, e, a);
			abort_run("vote output mismatch");
		end
	endtask

	task automatic check_status(input string name, input fault_status_t exp,
			input fault_status_t act);
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			abort_run("fault status mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			abort_run("flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// {cmp, result} of one replica
	function automatic logic [`FT_XLEN:0] ref_alu(input alu_req_t r);
		logic [`FT_XLEN-1:0] a;
		logic [`FT_XLEN-1:0] b;
		logic [`FT_XLEN-1:0] y;
		logic                c;
		a = r.operand_a;
		b = r.operand_b;
		y = '0;
		c = 1'b0;
		case (r.op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a + ~b + 1;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLL: y = a << b[4:0];
			ALU_SRL: y = a >> b[4:0];
			// signed less-than where differing sign bits decide
			ALU_SLT: c = (a[31] != b[31]) ? a[31] : (a < b);
			ALU_SLTU: c = a < b;
			ALU_EQ: c = (a ^ b) == '0;
			default: y = '0;
		endcase
		if (r.op == ALU_SLT || r.op == ALU_SLTU || r.op == ALU_EQ) begin
			y = {{(`FT_XLEN-1){1'b0}}, c};
		end
		return {c, y};
	endfunction

	// k-th lowest unit that is not on standby
	function automatic unit_idx_t slot_unit(input unit_idx_t spare, input int k);
		int seen;
		seen = 0;
		for (int u = 0; u < `FT_NUM_UNITS; u++) begin
			if (unit_idx_t'(u) != spare) begin
				if (seen == k) begin
					return unit_idx_t'(u);
				end
				seen++;
			end
		end
		return '0;
	endfunction

	function automatic vote_out_t expected_vote(input alu_req_vec_t reqs, input unit_idx_t spare);
		logic [`FT_XLEN-1:0] res [`FT_NUM_SLOTS];
		logic                c [`FT_NUM_SLOTS];
		logic [`FT_XLEN-1:0] voted;
		logic                vcmp;
		int                  ones;
		int                  nflag;
		logic                flagged;
		vote_out_t           v;
		for (int k = 0; k < `FT_NUM_SLOTS; k++) begin
			{c[k], res[k]} = ref_alu(reqs[slot_unit(spare, k)]);
		end
		// per-bit two-of-three count
		for (int b = 0; b < `FT_XLEN; b++) begin
			ones = int'(res[0][b]) + int'(res[1][b]) + int'(res[2][b]);
			voted[b] = ones >= 2;
		end
		ones = int'(c[0]) + int'(c[1]) + int'(c[2]);
		vcmp = ones >= 2;
		v = '0;
		nflag = 0;
		for (int k = 0; k < `FT_NUM_SLOTS; k++) begin
			flagged = (res[k] != voted) || (c[k] != vcmp);
			v.unit_err[slot_unit(spare, k)] = flagged;
			if (flagged) begin
				nflag++;
			end
		end
		v.valid = 1'b1;
		v.result = voted;
		v.cmp = vcmp;
		v.err_detected = nflag != 0;
		v.err_corrected = nflag == 1;
		return v;
	endfunction

	// one clock of the fault monitor with this cycle's unit error mask
	task automatic step_fault_model(input unit_mask_t errs);
		unit_mask_t perm_n;
		perm_n = perm_m;
		for (int u = 0; u < `FT_NUM_UNITS; u++) begin
			if (errs[u] && cnt_m[u] < CNT_SAT) begin
				cnt_m[u]++;
			end
			if (cnt_m[u] >= `FT_ERR_THRESHOLD) begin
				perm_n[u] = 1'b1;
			end
		end
		pulse_m = perm_n & ~perm_m;
		perm_m = perm_n;
	endtask

	////////////////////////////////////////////////////////////
	// output monitor on the falling edge
	////////////////////////////////////////////////////////////

	initial begin
		vote_out_t exp;
		vote_out_t act;
		forever begin
			@(negedge clk);
			if (rst_i) begin
				perm_m = '0;
				pulse_m = '0;
				for (int u = 0; u < `FT_NUM_UNITS; u++) begin
					cnt_m[u] = 0;
					pulse_seen[u] = 0;
				end
			end else begin
				check_status({phase_name, " status"}, fault_status_t'{perm_m, pulse_m},
					fault_status_t'{perm_faulty_o, perf_pulse_o});
				for (int u = 0; u < `FT_NUM_UNITS; u++) begin
					if (perf_pulse_o[u]) begin
						pulse_seen[u]++;
					end
				end
				if (valid_o) begin
					if (exp_q.size() == 0) begin
						abort_run("valid_o pulsed with no operation in flight");
					end
					exp = exp_q.pop_front();
					act = '{valid_o, result_o, cmp_o, err_detected_o, err_corrected_o, '0};
					check_vote({phase_name, " vote"}, exp, act);
					step_fault_model(exp.unit_err);
				end else begin
					check_flag({phase_name, " idle err_detected"}, 1'b0, err_detected_o);
					check_flag({phase_name, " idle err_corrected"}, 1'b0, err_corrected_o);
					step_fault_model('0);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic alu_req_t rand_req(input logic flip_visible);
		alu_req_t r;
		r.operand_a = $urandom();
		r.operand_b = $urandom();
		if (flip_visible) begin
			// ops where any operand A bit change reaches the result
			case ($urandom_range(2, 0))
				0: r.op = ALU_ADD;
				1: r.op = ALU_SUB;
				default: r.op = ALU_XOR;
			endcase
		end else begin
			r.op = alu_op_e'(4'($urandom_range(9, 0)));
			if (r.op == ALU_EQ && $urandom_range(1, 0) == 1) begin
				r.operand_b = r.operand_a;
			end
		end
		return r;
	endfunction

	function automatic alu_req_vec_t replicate(input alu_req_t r);
		alu_req_vec_t v;
		for (int u = 0; u < `FT_NUM_UNITS; u++) begin
			v[u] = r;
		end
		return v;
	endfunction

	task automatic issue_op(input alu_req_vec_t reqs, input unit_idx_t spare);
		@(posedge clk);
		valid_i <= 1'b1;
		req_i <= reqs;
		spare_sel_i <= spare;
		exp_q.push_back(expected_vote(reqs, spare));
		// random bubbles between operations
		if ($urandom_range(3, 0) == 0) begin
			@(posedge clk);
			valid_i <= 1'b0;
		end
	endtask

	// stop issuing and wait for every vote to come back
	task automatic drain_ops();
		@(posedge clk);
		valid_i <= 1'b0;
		for (int i = 0; i < 32 && exp_q.size() != 0; i++) begin
			@(posedge clk);
		end
		if (exp_q.size() != 0) begin
			abort_run("timed out waiting for valid_o");
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic apply_reset();
		rst_i <= 1'b1;
		valid_i <= 1'b0;
		repeat (8) @(posedge clk);
		rst_i <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		alu_req_vec_t reqs;
		unit_idx_t    spare;
		unit_idx_t    ua;
		unit_idx_t    ub;
		int           k1;
		int           bi;
		int           fault_unit;
		void'($urandom(32'h12514748));
		phase_name = "reset";
		req_i <= '0;
		spare_sel_i <= '0;
		apply_reset();
		@(negedge clk);
		check_flag("reset valid_o", 1'b0, valid_o);
		check_flag("reset err_detected_o", 1'b0, err_detected_o);
		check_flag("reset err_corrected_o", 1'b0, err_corrected_o);
		check_status("reset status", '0, fault_status_t'{perm_faulty_o, perf_pulse_o});

		phase_name = "fault_free";
		for (int n = 0; n < 60; n++) begin
			issue_op(replicate(rand_req(1'b0)), unit_idx_t'($urandom_range(3, 0)));
		end
		drain_ops();

		// one active unit with a flipped operand bit
		phase_name = "single_fault";
		for (int n = 0; n < 40; n++) begin
			reqs = replicate(rand_req(1'b1));
			spare = unit_idx_t'($urandom_range(3, 0));
			ua = slot_unit(spare, $urandom_range(2, 0));
			reqs[ua].operand_a ^= 32'h1 << $urandom_range(31, 0);
			issue_op(reqs, spare);
		end
		drain_ops();

		// two active units with flips in different result bits
		phase_name = "double_fault";
		for (int n = 0; n < 30; n++) begin
			reqs = replicate(rand_req(1'b0));
			reqs[0].op = ALU_XOR;
			reqs = replicate(reqs[0]);
			spare = unit_idx_t'($urandom_range(3, 0));
			k1 = $urandom_range(2, 0);
			ua = slot_unit(spare, k1);
			ub = slot_unit(spare, (k1 + 1 + $urandom_range(1, 0)) % 3);
			bi = $urandom_range(31, 0);
			reqs[ua].operand_a ^= 32'h1 << bi;
			reqs[ub].operand_a ^= 32'h1 << ((bi + 1 + $urandom_range(30, 0)) % 32);
			issue_op(reqs, spare);
		end
		drain_ops();
		apply_reset();

		// faults on the standby unit must never count
		phase_name = "standby_fault";
		for (int n = 0; n < 2 * `FT_ERR_THRESHOLD; n++) begin
			reqs = replicate(rand_req(1'b1));
			spare = unit_idx_t'($urandom_range(3, 0));
			reqs[spare].operand_a ^= 32'h1 << $urandom_range(31, 0);
			issue_op(reqs, spare);
		end
		drain_ops();
		@(negedge clk);
		check_status("standby_fault final status", '0,
			fault_status_t'{perm_faulty_o, perf_pulse_o});

		// one unit keeps failing past the threshold and into saturation
		phase_name = "permanent_fault";
		fault_unit = $urandom_range(3, 0);
		for (int n = 0; n < `FT_ERR_THRESHOLD + 10; n++) begin
			reqs = replicate(rand_req(1'b1));
			spare = unit_idx_t'((fault_unit + 1 + $urandom_range(2, 0)) % 4);
			reqs[fault_unit].operand_a ^= 32'h1 << $urandom_range(31, 0);
			issue_op(reqs, spare);
		end
		drain_ops();
		@(negedge clk);
		for (int u = 0; u < `FT_NUM_UNITS; u++) begin
			check_flag($sformatf("perm_faulty_o unit %0d", u), u == fault_unit,
				perm_faulty_o[u]);
			check_flag($sformatf("single perf_pulse_o unit %0d", u), u == fault_unit,
				pulse_seen[u] == 1);
			check_flag($sformatf("no extra perf_pulse_o unit %0d", u), 1'b1,
				pulse_seen[u] <= 1);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ft_alu_top.f ====
+incdir+.
ft_alu_pkg.sv
ft_status_pkg.sv
ft_issue_reg.sv
ft_alu_core.sv
ft_majority_voter.sv
ft_vote_stage.sv
ft_fault_monitor.sv
ft_alu_top.sv
tb_ft_alu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ft_alu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f ft_alu_top.f --top-module tb_ft_alu_top \
	-o tb_ft_alu_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/tb_ft_alu_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$SIM_LOG"; then
	exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
